/* files.f */
common/ppu_pkg.sv
core_op/add_sub.sv
core_op/core_mul.sv
core_op/core_div.sv
core_op/core_op.sv
verilog/posit_decode.sv
verilog/posit_encode.sv
verilog/ppu.sv
test/tb_ppu.sv

/* Makefile */
# Verilator build and run of the posit arithmetic unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build tb_ppu with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu \
		-Mdir obj_dir -f files.f
	./obj_dir/Vtb_ppu | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_ppu.sv */
`timescale 1ns/1ps

module tb_ppu
  import ppu_pkg::*;
();

  localparam int N = 16;
  localparam int ES = 1;
  localparam int MAX_SCALE = (N - 2) * (2 ** ES);  // scale of maxpos
  localparam int RANDOM_OPS = 2000;
  localparam int STIM_CYCLES = 4 + 64 + 2 * RANDOM_OPS;  // at most one idle per random op
  localparam int CYCLE_LIMIT = STIM_CYCLES + 50;
  localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};
  localparam logic [N-1:0] MAXPOS = {1'b0, {(N-1){1'b1}}};
  localparam logic [N-1:0] MINPOS = N'(1);

  logic         clk_i;
  logic         rst_n_i;
  logic         valid_i;
  operation_e   op_i;
  logic [N-1:0] posit1_i;
  logic [N-1:0] posit2_i;
  logic         valid_o;
  logic [N-1:0] posit_o;

  logic [N-1:0] exp_q[$];       // expected results in issue order
  logic [2:0]   valid_hist;     // valid_i seen on the last three rising edges
  logic [N-1:0] expected_posit;
  logic [31:0]  rng_state;
  int           errors;
  int           cycles;

  ppu #(.N(N), .ES(ES)) u_ppu (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .posit1_i (posit1_i),
    .posit2_i (posit2_i),
    .valid_o  (valid_o),
    .posit_o  (posit_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic real pow2(int s);
    real r;
    r = 1.0;
    for (int i = 0; i < s; i++) r = r * 2.0;
    for (int i = 0; i > s; i--) r = r / 2.0;
    return r;
  endfunction

  // value = (-1)^sign * 1.frac * 2^(k * 2^ES + e), missing exponent bits read as zero
  function automatic real posit_to_real(logic [N-1:0] p);
    logic [N-1:0] mag;
    logic         r0;
    int           idx;
    int           run;
    int           k;
    int           e;
    real          frac;
    real          w;
    if (p == '0) return 0.0;
    mag = p[N-1] ? -p : p;
    idx = N - 2;
    r0  = mag[idx];
    run = 0;
    while (idx >= 0 && mag[idx] == r0) begin
      run++;
      idx--;
    end
    idx--;  // skip the bit that ends the regime
    k = r0 ? run - 1 : -run;
    e = 0;
    for (int j = 0; j < ES; j++) begin
      e = e * 2;
      if (idx >= 0 && mag[idx]) e++;
      idx--;
    end
    frac = 1.0;
    w    = 0.5;
    while (idx >= 0) begin
      if (mag[idx]) frac = frac + w;
      w = w / 2.0;
      idx--;
    end
    return (p[N-1] ? -frac : frac) * pow2(k * (2 ** ES) + e);
  endfunction

  // the bit string is built as a real in units of the last posit bit, then rounded
  function automatic logic [N-1:0] real_to_posit(real x);
    real          m;
    real          p;
    real          rem;
    int           scale;
    int           k;
    int           e;
    int           hl;
    int           q;
    longint       head;
    logic [N-1:0] mag;
    if (x == 0.0) return '0;
    m = (x < 0.0) ? -x : x;
    scale = 0;
    while (m >= 2.0) begin
      m = m / 2.0;
      scale++;
    end
    while (m < 1.0) begin
      m = m * 2.0;
      scale--;
    end
    if (scale > MAX_SCALE) begin
      mag = MAXPOS;
    end else if (scale < -MAX_SCALE) begin
      mag = MINPOS;
    end else begin
      k = scale >>> ES;
      e = scale - k * (2 ** ES);
      if (k >= 0) begin
        head = ((longint'(1) << (k + 1)) - 1) << 1;  // k+1 ones and a closing zero
        hl   = k + 2;
      end else begin
        head = 1;  // -k zeros and a closing one
        hl   = 1 - k;
      end
      head = (head << ES) | longint'(e);
      hl   = hl + ES;
      p    = (real'(head) + (m - 1.0)) * pow2(N - 1 - hl);
      q    = $rtoi(p);
      rem  = p - real'(q);
      if (rem > 0.5 || (rem == 0.5 && q[0])) q++;  // nearest, ties to even
      if (q >= (1 << (N - 1))) mag = MAXPOS;
      else if (q == 0) mag = MINPOS;
      else mag = N'(q);
    end
    return (x < 0.0) ? -mag : mag;
  endfunction

  function automatic logic [N-1:0] ref_op(operation_e op, logic [N-1:0] a, logic [N-1:0] b);
    real x;
    real y;
    real r;
    if (a == NAR || b == NAR || (op == DIV && b == '0)) return NAR;
    x = posit_to_real(a);
    y = posit_to_real(b);
    case (op)
      ADD:     r = x + y;
      SUB:     r = x - y;
      MUL:     r = x * y;
      default: r = x / y;
    endcase
    return real_to_posit(r);
  endfunction

  task automatic check_value(input string name, input logic [N-1:0] actual,
                             input logic [N-1:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic issue(input operation_e op, input logic [N-1:0] a, input logic [N-1:0] b);
    @(negedge clk_i);
    valid_i  = 1'b1;
    op_i     = op;
    posit1_i = a;
    posit2_i = b;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      valid_i = 1'b0;
    end
  endtask

  // inputs are accepted on the rising edge, expected results queue up in order
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_hist <= '0;
    end else begin
      valid_hist <= {valid_hist[1:0], valid_i};
      if (valid_i) exp_q.push_back(ref_op(op_i, posit1_i, posit2_i));
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_value("valid_o", N'(valid_o), N'(valid_hist[2]));
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          $display("valid_o went high with no result pending");
          errors++;
        end else begin
          expected_posit = exp_q.pop_front();
          check_value("posit_o", posit_o, expected_posit);
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d results pending", cycles, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    valid_i   = 1'b0;
    op_i      = ADD;
    posit1_i  = '0;
    posit2_i  = '0;
    rng_state = 32'h9f06;
    errors    = 0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    idle(5);  // nothing may come out after reset

    // the reference itself against hand-decoded patterns
    check_value("reference 1+1", ref_op(ADD, 16'h4000, 16'h4000), 16'h5000);
    check_value("reference 1/3", ref_op(DIV, 16'h4000, real_to_posit(3.0)), 16'h2555);
    check_value("reference maxpos*maxpos", ref_op(MUL, MAXPOS, MAXPOS), MAXPOS);

    issue(ADD, real_to_posit(1.0), real_to_posit(1.0));
    issue(MUL, real_to_posit(3.0), real_to_posit(0.5));
    issue(SUB, real_to_posit(1.0), real_to_posit(1.0));
    issue(DIV, real_to_posit(1.0), real_to_posit(3.0));
    issue(ADD, real_to_posit(-1.5), real_to_posit(0.25));
    issue(DIV, real_to_posit(7.0), real_to_posit(-2.0));
    idle(2);
    issue(ADD, NAR, real_to_posit(1.0));
    issue(MUL, real_to_posit(1.0), NAR);
    issue(DIV, real_to_posit(1.0), '0);
    issue(MUL, real_to_posit(2.5), '0);
    issue(ADD, '0, real_to_posit(3.0));
    issue(SUB, '0, real_to_posit(3.0));
    issue(ADD, real_to_posit(3.0), '0);
    issue(DIV, '0, real_to_posit(5.0));
    idle(1);
    issue(MUL, MAXPOS, MAXPOS);
    issue(MUL, MINPOS, MINPOS);
    issue(DIV, MINPOS, MAXPOS);
    issue(ADD, MAXPOS, MAXPOS);
    idle(3);
    issue(ADD, 16'h4000, real_to_posit(pow2(-13)));      // tie, stays on the even pattern
    issue(ADD, 16'h4001, real_to_posit(pow2(-13)));      // tie, moves up to the even pattern
    issue(ADD, 16'h4000, real_to_posit(3.0 * pow2(-13)));
    idle(2);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rnd = next_random();
      issue(operation_e'(rnd[9:8]), N'(next_random() >> 16), N'(next_random() >> 16));
      if (rnd[14:12] == 3'd0) idle(1);  // an occasional gap between back-to-back ops
    end
    idle(1);

    for (int i = 0; i < 10 && exp_q.size() != 0; i++) @(negedge clk_i);
    idle(4);
    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out", exp_q.size());
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/ppu.sv */
`timescale 1ns/1ps

module ppu
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         valid_i,
  input  operation_e   op_i,
  input  logic [N-1:0] posit1_i,
  input  logic [N-1:0] posit2_i,
  output logic         valid_o,
  output logic [N-1:0] posit_o
);

  dec_stage_t  dec_q;   // decoded operands, stage 1 to 2
  core_stage_t core_q;  // raw result, stage 2 to 3

  posit_decode #(.N(N), .ES(ES)) u_posit_decode (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .posit1_i (posit1_i),
    .posit2_i (posit2_i),
    .dec_o    (dec_q)
  );

  core_op #(.N(N), .ES(ES)) u_core_op (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dec_i   (dec_q),
    .core_o  (core_q)
  );

  posit_encode #(.N(N), .ES(ES)) u_posit_encode (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .core_i  (core_q),
    .valid_o (valid_o),
    .posit_o (posit_o)
  );

endmodule

/* verilog/posit_encode.sv */
`timescale 1ns/1ps

module posit_encode
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  core_stage_t  core_i,
  output logic         valid_o,
  output logic [N-1:0] posit_o
);

  localparam int MAX_EXP = (N - 2) * (2 ** ES);  // scale of maxpos
  localparam int TAIL_W  = 2 + FRAC_FULL_SIZE - 1;  // up to two exponent bits, then the fraction
  localparam int BODY_W  = 2 + TAIL_W + N;

  logic [4:0]                lead_zeros;
  logic [FRAC_FULL_SIZE-1:0] frac_norm;
  logic signed [9:0]         scale;
  logic signed [9:0]         regime_k;
  logic [9:0]                shamt;
  logic [TAIL_W-1:0]         tail;
  logic [BODY_W-1:0]         seed;
  logic signed [BODY_W-1:0]  body;
  logic                      guard, sticky, round_up;
  logic [N-1:0]              mag;
  logic [N-1:0]              posit_d;

  always_comb begin
    lead_zeros = '0;
    for (int i = 0; i < FRAC_FULL_SIZE; i++) begin
      if (core_i.frac[i]) lead_zeros = 5'(FRAC_FULL_SIZE - 1 - i);
    end
    frac_norm = core_i.frac << lead_zeros;
    scale     = 10'(core_i.te) - 10'(lead_zeros) - 10'sd1;  // leading one now the hidden bit
    regime_k  = scale >>> ES;
    tail = {scale[1:0], frac_norm[FRAC_FULL_SIZE-2:0]} << (2 - ES);  // keep ES exponent bits
    // the arithmetic shift stretches the first regime bit into the whole run
    if (regime_k >= 0) begin
      seed  = {2'b10, tail, {N{1'b0}}};
      shamt = 10'(regime_k);
    end else begin
      seed  = {2'b01, tail, {N{1'b0}}};
      shamt = 10'(-regime_k - 10'sd1);
    end
    body = $signed(seed) >>> shamt;

    guard    = body[BODY_W-N];
    sticky   = (|body[BODY_W-N-1:0]) | core_i.frac_truncated;
    round_up = guard & (body[BODY_W-N+1] | sticky);  // nearest, ties to even
    mag      = {1'b0, body[BODY_W-1 -: N-1]} + N'(round_up);

    if (scale > MAX_EXP || mag[N-1]) begin
      mag = {1'b0, {(N-1){1'b1}}};  // saturate at maxpos
    end else if (scale < -MAX_EXP || mag == '0) begin
      mag = N'(1);  // a non-zero result stops at minpos
    end

    if (core_i.is_nar) begin
      posit_d = {1'b1, {(N-1){1'b0}}};
    end else if (core_i.is_zero) begin
      posit_d = '0;
    end else begin
      posit_d = core_i.sign ? -mag : mag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      posit_o <= '0;
    end else begin
      valid_o <= core_i.valid;
      posit_o <= posit_d;
    end
  end

endmodule

/* verilog/posit_decode.sv */
`timescale 1ns/1ps

module posit_decode
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          valid_i,
  input  operation_e    op_i,
  input  logic [N-1:0]  posit1_i,
  input  logic [N-1:0]  posit2_i,
  output dec_stage_t    dec_o
);

  dec_stage_t dec_d;

  function automatic fir_t decode_posit(logic [N-1:0] posit);
    logic [N-1:0] mag;
    logic [N-2:0] body;
    logic [N-2:0] run_bits;
    logic [N-2:0] rest;
    int           run;
    int           regime_k;
    int           exp_val;
    fir_t         fir;
    fir.sign    = posit[N-1];
    fir.is_zero = (posit == '0);
    fir.is_nar  = (posit == {1'b1, {(N-1){1'b0}}});
    mag  = fir.sign ? -posit : posit;  // negative posits decode from their two's complement
    body = mag[N-2:0];
    run_bits = body ^ {(N-1){body[N-2]}};  // the regime run turns into leading zeros
    run = N - 1;
    for (int i = 0; i < N - 1; i++) begin
      if (run_bits[i]) run = N - 2 - i;  // highest differing bit wins
    end
    regime_k = body[N-2] ? run - 1 : -run;
    rest     = body << (run + 1);  // drop the run and its terminating bit
    exp_val  = int'(rest >> (N - 1 - ES));
    fir.total_exponent = exponent_t'(regime_k * (2 ** ES) + exp_val);
    fir.mant = MANT_FIELD_SIZE'({1'b1, rest << ES}) << (MANT_FIELD_SIZE - N);
    return fir;
  endfunction

  always_comb begin
    dec_d.valid = valid_i;
    dec_d.op    = op_i;
    dec_d.fir1  = decode_posit(posit1_i);
    dec_d.fir2  = decode_posit(posit2_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_o.valid <= 1'b0;  // operand fields are don't care until the first valid
    end else begin
      dec_o <= dec_d;
    end
  end

  a_op_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> !$isunknown(op_i)
  );

endmodule

/* core_op/core_op.sv */
`timescale 1ns/1ps

module core_op
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dec_stage_t  dec_i,
  output core_stage_t core_o
);

  localparam int MANT_SIZE = mant_size(N, ES);
  localparam int MANT_ADD_RESULT_SIZE = mant_add_result_size(N, ES);
  localparam int MANT_MUL_RESULT_SIZE = mant_mul_result_size(N, ES);
  localparam int MANT_DIV_RESULT_SIZE = mant_div_result_size(N, ES);

  fir_t                            fir1, fir2;
  logic [MANT_SIZE-1:0]            mant1, mant2;
  logic [MANT_ADD_RESULT_SIZE-1:0] mant_as;
  logic [MANT_MUL_RESULT_SIZE-1:0] mant_mul;
  logic [MANT_DIV_RESULT_SIZE-1:0] mant_div;
  logic                            sign_as, sign_mul, sign_div;
  exponent_t                       te_as, te_mul, te_div;
  logic                            trunc_as, trunc_mul, trunc_div;
  logic                            is_add_sub;
  core_stage_t                     core_d;

  assign fir1 = dec_i.fir1;
  assign fir2 = dec_i.fir2;
  assign mant1 = fir1.mant[MANT_FIELD_SIZE-1 -: MANT_SIZE];
  assign mant2 = fir2.mant[MANT_FIELD_SIZE-1 -: MANT_SIZE];
  assign is_add_sub = (dec_i.op == ADD) || (dec_i.op == SUB);

  add_sub #(.N(N), .ES(ES)) u_add_sub (
    .sign1_i(fir1.sign), .sign2_i(fir2.sign),
    .te1_i(fir1.total_exponent), .te2_i(fir2.total_exponent),
    .mant1_i(mant1), .mant2_i(mant2), .sub_i(dec_i.op == SUB),
    .sign_o(sign_as), .te_o(te_as), .mant_o(mant_as), .frac_truncated_o(trunc_as)
  );

  core_mul #(.N(N), .ES(ES)) u_core_mul (
    .sign1_i(fir1.sign), .sign2_i(fir2.sign),
    .te1_i(fir1.total_exponent), .te2_i(fir2.total_exponent),
    .mant1_i(mant1), .mant2_i(mant2),
    .sign_o(sign_mul), .te_o(te_mul), .mant_o(mant_mul), .frac_truncated_o(trunc_mul)
  );

  core_div #(.N(N), .ES(ES)) u_core_div (
    .sign1_i(fir1.sign), .sign2_i(fir2.sign),
    .te1_i(fir1.total_exponent), .te2_i(fir2.total_exponent),
    .mant1_i(mant1), .mant2_i(mant2),
    .sign_o(sign_div), .te_o(te_div), .mant_o(mant_div), .frac_truncated_o(trunc_div)
  );

  // results are left aligned and the integer bits move into the exponent
  always_comb begin
    core_d.valid = dec_i.valid;
    case (dec_i.op)
      ADD, SUB: begin
        core_d.sign = sign_as;
        core_d.te   = te_as + 8'sd2;  // two integer bits above the point
        core_d.frac = FRAC_FULL_SIZE'(mant_as) << (FRAC_FULL_SIZE - MANT_ADD_RESULT_SIZE);
        core_d.frac_truncated = trunc_as;
      end
      MUL: begin
        core_d.sign = sign_mul;
        core_d.te   = te_mul + 8'sd2;
        core_d.frac = FRAC_FULL_SIZE'(mant_mul) << (FRAC_FULL_SIZE - MANT_MUL_RESULT_SIZE);
        core_d.frac_truncated = trunc_mul;
      end
      default: begin
        core_d.sign = sign_div;
        core_d.te   = te_div + 8'sd1;  // quotient carries only one integer bit
        core_d.frac = FRAC_FULL_SIZE'(mant_div) << (FRAC_FULL_SIZE - MANT_DIV_RESULT_SIZE);
        core_d.frac_truncated = trunc_div;
      end
    endcase
    // adding a zero hands back the other operand unchanged
    if (is_add_sub && fir1.is_zero && !fir2.is_zero) begin
      core_d.sign = fir2.sign ^ (dec_i.op == SUB);
      core_d.te   = fir2.total_exponent + 8'sd1;
      core_d.frac = FRAC_FULL_SIZE'(fir2.mant) << (FRAC_FULL_SIZE - MANT_FIELD_SIZE);
      core_d.frac_truncated = 1'b0;
    end else if (is_add_sub && fir2.is_zero && !fir1.is_zero) begin
      core_d.sign = fir1.sign;
      core_d.te   = fir1.total_exponent + 8'sd1;
      core_d.frac = FRAC_FULL_SIZE'(fir1.mant) << (FRAC_FULL_SIZE - MANT_FIELD_SIZE);
      core_d.frac_truncated = 1'b0;
    end
    core_d.is_nar = fir1.is_nar || fir2.is_nar || ((dec_i.op == DIV) && fir2.is_zero);
    case (dec_i.op)
      MUL:     core_d.is_zero = fir1.is_zero || fir2.is_zero;
      DIV:     core_d.is_zero = fir1.is_zero;
      default: core_d.is_zero = (fir1.is_zero && fir2.is_zero) ||
                                (!fir1.is_zero && !fir2.is_zero && (mant_as == '0));
    endcase
    if (core_d.is_nar) core_d.is_zero = 1'b0;  // NaR wins over every zero rule
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_o.valid <= 1'b0;
    end else begin
      core_o <= core_d;
    end
  end

  // the encoder needs a leading one in every result that is neither zero nor NaR
  a_finite_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    core_o.valid && !core_o.is_zero && !core_o.is_nar |-> core_o.frac != '0
  );

endmodule

/* core_op/core_div.sv */
`timescale 1ns/1ps

module core_div
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1,
  localparam int MANT_SIZE = mant_size(N, ES),
  localparam int MANT_DIV_RESULT_SIZE = mant_div_result_size(N, ES)
) (
  input  logic                            sign1_i,
  input  logic                            sign2_i,
  input  exponent_t                       te1_i,
  input  exponent_t                       te2_i,
  input  logic [MANT_SIZE-1:0]            mant1_i,
  input  logic [MANT_SIZE-1:0]            mant2_i,
  output logic                            sign_o,
  output exponent_t                       te_o,
  output logic [MANT_DIV_RESULT_SIZE-1:0] mant_o,
  output logic                            frac_truncated_o
);

  logic [MANT_SIZE:0] rem;  // stays below twice the divisor

  // restoring long division, first quotient bit is the single integer bit
  always_comb begin
    rem    = {1'b0, mant1_i};
    mant_o = '0;
    for (int i = MANT_DIV_RESULT_SIZE - 1; i >= 0; i--) begin
      if (rem >= {1'b0, mant2_i}) begin
        mant_o[i] = 1'b1;
        rem       = rem - {1'b0, mant2_i};
      end
      rem = rem << 1;
    end
  end

  assign frac_truncated_o = |rem;  // any remainder means the quotient is inexact

  assign sign_o = sign1_i ^ sign2_i;
  assign te_o   = te1_i - te2_i;

endmodule

/* core_op/core_mul.sv */
`timescale 1ns/1ps

module core_mul
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1,
  localparam int MANT_SIZE = mant_size(N, ES),
  localparam int MANT_MUL_RESULT_SIZE = mant_mul_result_size(N, ES)
) (
  input  logic                            sign1_i,
  input  logic                            sign2_i,
  input  exponent_t                       te1_i,
  input  exponent_t                       te2_i,
  input  logic [MANT_SIZE-1:0]            mant1_i,
  input  logic [MANT_SIZE-1:0]            mant2_i,
  output logic                            sign_o,
  output exponent_t                       te_o,
  output logic [MANT_MUL_RESULT_SIZE-1:0] mant_o,
  output logic                            frac_truncated_o
);

  // the product lies in [1, 4) with two integer bits on top
  assign mant_o = MANT_MUL_RESULT_SIZE'(mant1_i) * MANT_MUL_RESULT_SIZE'(mant2_i);

  assign sign_o = sign1_i ^ sign2_i;
  assign te_o   = te1_i + te2_i;

  assign frac_truncated_o = 1'b0;  // full product kept, nothing is lost here

endmodule

/* core_op/add_sub.sv */
`timescale 1ns/1ps

module add_sub
  import ppu_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1,
  localparam int MANT_SIZE = mant_size(N, ES),
  localparam int MANT_ADD_RESULT_SIZE = mant_add_result_size(N, ES)
) (
  input  logic                            sign1_i,
  input  logic                            sign2_i,
  input  exponent_t                       te1_i,
  input  exponent_t                       te2_i,
  input  logic [MANT_SIZE-1:0]            mant1_i,
  input  logic [MANT_SIZE-1:0]            mant2_i,
  input  logic                            sub_i,
  output logic                            sign_o,
  output exponent_t                       te_o,
  output logic [MANT_ADD_RESULT_SIZE-1:0] mant_o,
  output logic                            frac_truncated_o
);

  localparam int EXT_SIZE = 2 * MANT_SIZE;  // mantissa padded with guard room

  logic                            sign2_eff;
  logic                            swap;
  logic                            sign_big, sign_small;
  exponent_t                       te_big, te_small;
  logic [MANT_SIZE-1:0]            mant_big, mant_small;
  logic [8:0]                      exp_diff;
  logic [2*EXT_SIZE-1:0]           shift_buf;
  logic [EXT_SIZE-1:0]             small_shifted;
  logic                            sticky;
  logic [MANT_ADD_RESULT_SIZE-1:0] opnd_big, opnd_small;

  assign sign2_eff = sign2_i ^ sub_i;  // subtraction is addition of the negated operand

  // larger magnitude goes first so the difference never goes negative
  assign swap = (te2_i > te1_i) || ((te2_i == te1_i) && (mant2_i > mant1_i));

  always_comb begin
    sign_big   = swap ? sign2_eff : sign1_i;
    sign_small = swap ? sign1_i : sign2_eff;
    te_big     = swap ? te2_i : te1_i;
    te_small   = swap ? te1_i : te2_i;
    mant_big   = swap ? mant2_i : mant1_i;
    mant_small = swap ? mant1_i : mant2_i;
    exp_diff   = 9'(te_big) - 9'(te_small);
  end

  always_comb begin
    shift_buf = {mant_small, {MANT_SIZE{1'b0}}, {EXT_SIZE{1'b0}}} >> exp_diff;
    if (exp_diff >= 9'(EXT_SIZE)) begin
      small_shifted = '0;
      sticky        = 1'b1;  // the hidden bit alone is enough to leave a remainder
    end else begin
      small_shifted = shift_buf[2*EXT_SIZE-1:EXT_SIZE];
      sticky        = |shift_buf[EXT_SIZE-1:0];
    end
  end

  // sticky rides in an extra bit below the grid so a subtraction still rounds right
  assign opnd_big   = {1'b0, mant_big, {MANT_SIZE{1'b0}}, 1'b0};
  assign opnd_small = {1'b0, small_shifted, sticky};

  assign mant_o = (sign_big ^ sign_small) ? opnd_big - opnd_small : opnd_big + opnd_small;

  assign sign_o           = sign_big;
  assign te_o             = te_big;
  assign frac_truncated_o = sticky;

endmodule

/* common/ppu_pkg.sv */
package ppu_pkg;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    DIV = 2'd3
  } operation_e;

  typedef logic signed [7:0] exponent_t;  // regime * 2^ES + exponent, enough for N <= 16

  localparam int MANT_FIELD_SIZE = 16;  // hidden bit sits in the top position
  localparam int FRAC_FULL_SIZE = 32;

  typedef struct packed {
    logic                       sign;
    exponent_t                  total_exponent;
    logic [MANT_FIELD_SIZE-1:0] mant;
    logic                       is_zero;
    logic                       is_nar;
  } fir_t;

  typedef struct packed {
    logic       valid;
    operation_e op;
    fir_t       fir1;
    fir_t       fir2;
  } dec_stage_t;

  typedef struct packed {
    logic                      valid;
    logic                      sign;
    exponent_t                 te;
    logic [FRAC_FULL_SIZE-1:0] frac;  // value is 0.frac * 2^te
    logic                      frac_truncated;
    logic                      is_zero;
    logic                      is_nar;
  } core_stage_t;

  // hidden bit plus the longest fraction a posit of this size can hold
  function automatic int mant_size(int n, int es);
    return n - es - 2;
  endfunction

  function automatic int mant_add_result_size(int n, int es);
    return 2 * mant_size(n, es) + 2;  // guard room, a sticky bit and the carry
  endfunction

  function automatic int mant_mul_result_size(int n, int es);
    return 2 * mant_size(n, es);
  endfunction

  // the quotient is never narrower than the add result, so rounding stays exact
  function automatic int mant_div_result_size(int n, int es);
    if (mant_add_result_size(n, es) > FRAC_FULL_SIZE) begin
      return mant_add_result_size(n, es);
    end
    return FRAC_FULL_SIZE;
  endfunction

endpackage
